// ==== design/ps2_pkg.sv ====
package ps2_pkg;

  // ------------------------------------------------------------
  // Widths and constants
  // ------------------------------------------------------------
  localparam int BYTE_W       = 8;   // PS/2 data byte
  localparam int SAMPLE_COUNT = 8;   // Samples taken per PS/2 bit
  localparam int SAMPLE_CNT_W = 4;   // Holds 0 to SAMPLE_COUNT
  localparam int DIGIT_BASE   = 10;  // Decimal display
  localparam int NUM_DIGITS   = 3;   // Hundreds, tens and ones
  localparam int DIGIT_W      = 4;   // One BCD digit
  localparam int SEG_W        = 7;   // Segments a to g

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------
  typedef logic [BYTE_W-1:0]       byte_t;
  typedef logic [DIGIT_W-1:0]      digit_t;
  typedef logic [SEG_W-1:0]        seg_t;         // Active low, bit 0 is a
  typedef logic [SAMPLE_CNT_W-1:0] sample_cnt_t;

  // ------------------------------------------------------------
  // State machines
  // ------------------------------------------------------------

  // Frame receiver
  typedef enum logic [1:0] {
    FRAME_IDLE,    // Waiting for a low start bit
    FRAME_DATA,    // Eight data bits, LSB first
    FRAME_PARITY,  // Odd parity bit
    FRAME_STOP     // Stop bit, must be high
  } frame_state_t;

  // Digit converter
  typedef enum logic [1:0] {
    CONV_IDLE,     // Waiting for a byte
    CONV_DIVIDE,   // Divider running
    CONV_STORE     // Remainder written, next division or finish
  } conv_state_t;

endpackage

// ==== design/edge_sync.sv ====
module edge_sync
(
  input  logic clk,
  input  logic async_in,  // Asynchronous line
  output logic level,     // Synchronized copy
  output logic fall       // One cycle on a falling edge
);
  logic meta;   // First stage, may go metastable
  logic hist;   // Previous synchronized value

  // Two flop synchronizer followed by a history flop
  always_ff @(posedge clk)
  begin
    meta  <= async_in;
    level <= meta;
    hist  <= level;
  end

  // High while the new low level meets the old high one
  assign fall = hist & ~level;

endmodule

// ==== design/bit_sampler.sv ====
module bit_sampler
(
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,    // Raw PS/2 clock
  input  logic ps2_data,   // Raw PS/2 data
  output logic bit_valid,  // One cycle after the last sample
  output logic bit_value   // Majority of the window
);
  import ps2_pkg::*;

  logic        clk_fall;    // Falling PS/2 clock, clk domain
  logic        data_level;  // Synchronized data line
  logic        active;      // Sample window open
  sample_cnt_t sample_cnt;  // Samples taken so far
  sample_cnt_t ones_cnt;    // Ones seen so far
  sample_cnt_t ones_next;   // Ones count including this cycle

  edge_sync u_clk_sync
  (
    .clk      (clk),
    .async_in (ps2_clk),
    .level    (),
    .fall     (clk_fall)
  );

  edge_sync u_data_sync
  (
    .clk      (clk),
    .async_in (ps2_data),
    .level    (data_level),
    .fall     ()
  );

  assign ones_next = ones_cnt + sample_cnt_t'(data_level);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      active     <= 1'b0;
      sample_cnt <= '0;
      ones_cnt   <= '0;
      bit_valid  <= 1'b0;
      bit_value  <= 1'b0;
    end
    else
    begin
      bit_valid <= 1'b0;
      if (clk_fall)            // New bit, restart the window
      begin
        active     <= 1'b1;
        sample_cnt <= '0;
        ones_cnt   <= '0;
      end
      else if (active)
      begin
        sample_cnt <= sample_cnt + 1'b1;
        ones_cnt   <= ones_next;
        if (sample_cnt == sample_cnt_t'(SAMPLE_COUNT - 1))   // Last sample
        begin
          active    <= 1'b0;
          bit_valid <= 1'b1;
          bit_value <= (ones_next > sample_cnt_t'(SAMPLE_COUNT / 2));
        end
      end
    end
  end

  // No decision while the window is still collecting samples
  a_valid_after_window : assert property (
    @(posedge clk) disable iff (reset) clk_fall |=> !bit_valid [*SAMPLE_COUNT]
  ) else $error("bit_valid while sample window open");

endmodule

// ==== design/ps2_frame_receiver.sv ====
module ps2_frame_receiver
(
  input  logic           clk,
  input  logic           reset,
  input  logic           bit_valid,    // Strobe from the sampler
  input  logic           bit_value,
  output ps2_pkg::byte_t rx_data,      // Last accepted byte
  output logic           rx_valid,     // Good frame pulse
  output logic           frame_error   // Bad parity or stop pulse
);
  import ps2_pkg::*;

  frame_state_t              state;
  logic [$clog2(BYTE_W)-1:0] bit_cnt;     // Data bits received
  byte_t                     shift_reg;   // Assembles the byte
  logic                      parity;      // XOR of data bits so far
  logic                      parity_bad;  // Latched at the parity bit

  // ------------------------------------------------------------
  // Frame state machine
  // ------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= FRAME_IDLE;
      bit_cnt     <= '0;
      parity      <= 1'b0;
      parity_bad  <= 1'b0;
      rx_data     <= '0;
      rx_valid    <= 1'b0;
      frame_error <= 1'b0;
    end
    else
    begin
      rx_valid    <= 1'b0;   // Pulses by default
      frame_error <= 1'b0;
      if (bit_valid)
      begin
        unique case (state)
          FRAME_IDLE:
          begin
            if (!bit_value)   // Start bit
            begin
              state   <= FRAME_DATA;
              bit_cnt <= '0;
              parity  <= 1'b0;
            end
          end
          FRAME_DATA:
          begin
            parity  <= parity ^ bit_value;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BYTE_W - 1)
              state <= FRAME_PARITY;
          end
          FRAME_PARITY:
          begin
            // Odd parity over nine bits, so XOR must come out one
            parity_bad <= ~(parity ^ bit_value);
            state      <= FRAME_STOP;
          end
          FRAME_STOP:
          begin
            if (parity_bad || !bit_value)
              frame_error <= 1'b1;
            else
            begin
              rx_valid <= 1'b1;
              rx_data  <= shift_reg;
            end
            state <= FRAME_IDLE;
          end
          default: state <= FRAME_IDLE;
        endcase
      end
    end
  end

  // Data path, LSB arrives first so shift in from the top
  always_ff @(posedge clk)
  begin
    if (bit_valid && state == FRAME_DATA)
      shift_reg <= {bit_value, shift_reg[BYTE_W-1:1]};
  end

  // One outcome per frame, a single cycle wide
  a_one_outcome : assert property (
    @(posedge clk) disable iff (reset)
    (rx_valid || frame_error) |-> !(rx_valid && frame_error) ##1 !(rx_valid || frame_error)
  ) else $error("outcome pulses overlap or last longer than one cycle");

endmodule

// ==== design/base_divider.sv ====
module base_divider
(
  input  logic            clk,
  input  logic            reset,
  input  logic            start,      // Loads the dividend
  input  ps2_pkg::byte_t  dividend,
  output ps2_pkg::byte_t  quotient,   // Held until next start
  output ps2_pkg::digit_t remainder,
  output logic            done        // BYTE_W+1 cycles after start
);
  import ps2_pkg::*;

  byte_t                   shift_q;      // Dividend out at MSB, quotient in at LSB
  byte_t                   part_rem;     // Partial remainder, two's complement
  byte_t                   rem_shifted;
  byte_t                   rem_step;     // After add or subtract
  byte_t                   rem_fixed;    // Final correction applied
  logic [$clog2(BYTE_W):0] step_cnt;     // Steps left
  logic                    busy;

  assign quotient  = shift_q;
  assign remainder = part_rem[DIGIT_W-1:0];   // Below base after correction

  // ------------------------------------------------------------
  // One non-restoring step
  // ------------------------------------------------------------
  always_comb
  begin
    rem_shifted = {part_rem[BYTE_W-2:0], shift_q[BYTE_W-1]};
    if (part_rem[BYTE_W-1])                 // Negative, add back
      rem_step = rem_shifted + byte_t'(DIGIT_BASE);
    else
      rem_step = rem_shifted - byte_t'(DIGIT_BASE);
    // Negative result on the last step gets the divisor back
    rem_fixed = rem_step[BYTE_W-1] ? rem_step + byte_t'(DIGIT_BASE) : rem_step;
  end

  // Control
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy     <= 1'b0;
      step_cnt <= '0;
      done     <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        busy     <= 1'b1;
        step_cnt <= ($clog2(BYTE_W) + 1)'(BYTE_W);
      end
      else if (busy)
      begin
        step_cnt <= step_cnt - 1'b1;
        if (step_cnt == 1)   // Last step
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Data path
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      shift_q  <= dividend;
      part_rem <= '0;
    end
    else if (busy)
    begin
      shift_q  <= {shift_q[BYTE_W-2:0], ~rem_step[BYTE_W-1]};   // Quotient bit
      part_rem <= (step_cnt == 1) ? rem_fixed : rem_step;
    end
  end

  a_rem_in_range : assert property (
    @(posedge clk) disable iff (reset) done |-> (remainder < DIGIT_BASE)
  ) else $error("remainder not below base at done");

endmodule

// ==== design/digit_converter.sv ====
module digit_converter
(
  input  logic            clk,
  input  logic            reset,
  input  logic            load,          // Taken only when idle
  input  ps2_pkg::byte_t  value,
  output ps2_pkg::digit_t ones,
  output ps2_pkg::digit_t tens,
  output ps2_pkg::digit_t hundreds,
  output logic            digits_valid   // New digits on the outputs
);
  import ps2_pkg::*;

  conv_state_t                   state;
  logic [$clog2(NUM_DIGITS)-1:0] digit_idx;    // Digit being produced, ones first
  byte_t                         work_value;   // Next dividend
  digit_t                        work_digits [NUM_DIGITS];
  digit_t                        out_digits  [NUM_DIGITS];
  logic                          div_start;
  logic                          div_done;
  byte_t                         div_quot;
  digit_t                        div_rem;

  base_divider u_divider
  (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .dividend  (work_value),
    .quotient  (div_quot),
    .remainder (div_rem),
    .done      (div_done)
  );

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state        <= CONV_IDLE;
      digit_idx    <= '0;
      div_start    <= 1'b0;
      digits_valid <= 1'b0;
      for (int i = 0; i < NUM_DIGITS; i++)
        out_digits[i] <= '0;           // Display shows 000
    end
    else
    begin
      div_start    <= 1'b0;
      digits_valid <= 1'b0;
      unique case (state)
        CONV_IDLE:
          if (load)
          begin
            work_value <= value;
            digit_idx  <= '0;
            div_start  <= 1'b1;
            state      <= CONV_DIVIDE;
          end
        CONV_DIVIDE:
          if (div_done)
            state <= CONV_STORE;       // Divider outputs now hold
        CONV_STORE:
        begin
          work_digits[digit_idx] <= div_rem;
          work_value             <= div_quot;   // Quotient feeds the next pass
          if (digit_idx == NUM_DIGITS - 1)
          begin
            // Publish all digits at once, newest remainder taken directly
            for (int i = 0; i < NUM_DIGITS; i++)
              out_digits[i] <= (i == digit_idx) ? div_rem : work_digits[i];
            digits_valid <= 1'b1;
            state        <= CONV_IDLE;
          end
          else
          begin
            digit_idx <= digit_idx + 1'b1;
            div_start <= 1'b1;
            state     <= CONV_DIVIDE;
          end
        end
        default: state <= CONV_IDLE;
      endcase
    end
  end

  assign ones     = out_digits[0];
  assign tens     = out_digits[1];
  assign hundreds = out_digits[2];

  // Divider must finish before it is started again
  a_no_restart : assert property (
    @(posedge clk) disable iff (reset)
    div_start |=> (!div_start throughout div_done[->1])
  ) else $error("divider started while busy");

endmodule

// ==== design/seg7_encoder.sv ====
module seg7_encoder
(
  input  ps2_pkg::digit_t digit,
  output ps2_pkg::seg_t   seg     // Active low, bit 0 is a, bit 6 is g
);
  import ps2_pkg::*;

  // Segment order in the pattern is g f e d c b a
  always_comb
  begin
    unique case (digit)
      digit_t'(0): seg = 7'b1000000;   // a to f
      digit_t'(1): seg = 7'b1111001;   // b and c
      digit_t'(2): seg = 7'b0100100;
      digit_t'(3): seg = 7'b0110000;
      digit_t'(4): seg = 7'b0011001;
      digit_t'(5): seg = 7'b0010010;
      digit_t'(6): seg = 7'b0000010;
      digit_t'(7): seg = 7'b1111000;
      digit_t'(8): seg = 7'b0000000;   // All lit
      digit_t'(9): seg = 7'b0010000;
      default:     seg = 7'b1111111;   // Blank above nine
    endcase
  end

endmodule

// ==== design/ps2_display_top.sv ====
module ps2_display_top
(
  input  logic           clk,
  input  logic           reset,
  input  logic           ps2_clk,       // Asynchronous
  input  logic           ps2_data,      // Asynchronous
  output ps2_pkg::byte_t rx_data,
  output logic           rx_valid,
  output logic           frame_error,
  output logic           digits_valid,
  output ps2_pkg::seg_t  seg_ones,
  output ps2_pkg::seg_t  seg_tens,
  output ps2_pkg::seg_t  seg_hundreds
);
  import ps2_pkg::*;

  logic   bit_valid;
  logic   bit_value;
  digit_t ones;
  digit_t tens;
  digit_t hundreds;

  // ------------------------------------------------------------
  // Receive path
  // ------------------------------------------------------------
  bit_sampler u_sampler
  (
    .clk       (clk),
    .reset     (reset),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .bit_valid (bit_valid),
    .bit_value (bit_value)
  );

  ps2_frame_receiver u_receiver
  (
    .clk         (clk),
    .reset       (reset),
    .bit_valid   (bit_valid),
    .bit_value   (bit_value),
    .rx_data     (rx_data),
    .rx_valid    (rx_valid),
    .frame_error (frame_error)
  );

  // ------------------------------------------------------------
  // Display path
  // ------------------------------------------------------------
  digit_converter u_converter
  (
    .clk          (clk),
    .reset        (reset),
    .load         (rx_valid),      // Dropped if still converting
    .value        (rx_data),
    .ones         (ones),
    .tens         (tens),
    .hundreds     (hundreds),
    .digits_valid (digits_valid)
  );

  seg7_encoder u_seg_ones     (.digit(ones),     .seg(seg_ones));
  seg7_encoder u_seg_tens     (.digit(tens),     .seg(seg_tens));
  seg7_encoder u_seg_hundreds (.digit(hundreds), .seg(seg_hundreds));

endmodule

// ==== tests/ps2_checker.sv ====
module ps2_checker
(
  input  logic           clk,
  input  logic           reset,
  input  logic           test_start,    // One cycle, new frame on the way
  input  int             test_id,
  input  ps2_pkg::byte_t exp_byte,
  input  logic           exp_accept,    // Frame should be accepted
  input  ps2_pkg::byte_t rx_data,
  input  logic           rx_valid,
  input  logic           frame_error,
  input  logic           digits_valid,
  input  ps2_pkg::seg_t  seg_ones,
  input  ps2_pkg::seg_t  seg_tens,
  input  ps2_pkg::seg_t  seg_hundreds,
  output int             checks_done,   // Frame tests finished
  output int             pass_count,
  output int             fail_count
);
  timeunit 1ns;
  timeprecision 1ps;
  import ps2_pkg::*;

  localparam int RESET_TIMEOUT   = 100;
  localparam int OUTCOME_TIMEOUT = 1500;  // Whole frame is about 900 cycles
  localparam int DIGITS_TIMEOUT  = 200;

  // Active low g..a, digits 0 to 9
  seg_t  seg_table [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
                            7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
  byte_t last_good;   // Last byte the DUT should have accepted
  int    rx_cnt;      // Pulse counters since reset
  int    err_cnt;
  logic  test_ok;

  // Count outcome pulses, sampled mid-cycle
  always @(negedge clk)
  begin
    if (reset)
    begin
      rx_cnt  <= 0;
      err_cnt <= 0;
    end
    else
    begin
      rx_cnt  <= rx_cnt + rx_valid;
      err_cnt <= err_cnt + frame_error;
    end
  end

  task automatic check_hex(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
    begin
      $display("[ERROR] %s expected %h got %h", name, exp, act);
      test_ok = 1'b0;
    end
  endtask

  task automatic report(input string what);
    $display("%s: %s", what, test_ok ? "pass" : "fail");
    if (test_ok)
      pass_count++;
    else
      fail_count++;
  endtask

  // ------------------------------------------------------------
  // One frame, from start strobe to display update
  // ------------------------------------------------------------
  task automatic check_frame();
    int waited;
    int rx_before;
    int err_before;
    string what;
    test_ok    = 1'b1;
    rx_before  = rx_cnt;
    err_before = err_cnt;
    what       = $sformatf("Test %0d byte %h", test_id, exp_byte);
    waited     = 0;
    while (!(rx_valid || frame_error) && waited < OUTCOME_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!(rx_valid || frame_error))
    begin
      $display("%s: neither rx_valid nor frame_error within %0d cycles", what, waited);
      test_ok = 1'b0;
    end
    else if (exp_accept)
    begin
      check_hex("rx_data", exp_byte, rx_data);
      waited = 0;
      while (!digits_valid && waited < DIGITS_TIMEOUT)
      begin
        @(negedge clk);
        waited++;
      end
      if (!digits_valid)
      begin
        $display("%s: digits_valid never pulsed after the byte", what);
        test_ok = 1'b0;
      end
      else
      begin
        check_hex("seg_hundreds", seg_table[exp_byte / 100], seg_hundreds);
        check_hex("seg_tens", seg_table[(exp_byte / 10) % 10], seg_tens);
        check_hex("seg_ones", seg_table[exp_byte % 10], seg_ones);
      end
      last_good = exp_byte;
    end
    else
      check_hex("rx_data", last_good, rx_data);   // Rejected frame keeps old byte
    repeat (4) @(negedge clk);                     // Let the counters catch up
    check_hex("rx_valid pulses", exp_accept ? 8'd1 : 8'd0, rx_cnt - rx_before);
    check_hex("frame_error pulses", exp_accept ? 8'd0 : 8'd1, err_cnt - err_before);
    report(what);
    checks_done++;
  endtask

  initial
  begin
    int waited;
    checks_done = 0;
    pass_count  = 0;
    fail_count  = 0;
    last_good   = '0;
    test_ok     = 1'b1;
    waited      = 0;
    while (reset !== 1'b0 && waited < RESET_TIMEOUT)
    begin
      @(posedge clk);
      waited++;
    end
    if (reset !== 1'b0)
    begin
      $display("Reset was never released");
      test_ok = 1'b0;
    end
    else
    begin
      @(negedge clk);                      // Idle values right after reset
      check_hex("rx_valid", 8'd0, rx_valid);
      check_hex("frame_error", 8'd0, frame_error);
      check_hex("digits_valid", 8'd0, digits_valid);
      check_hex("rx_data", 8'd0, rx_data);
      check_hex("seg_ones", seg_table[0], seg_ones);
      check_hex("seg_tens", seg_table[0], seg_tens);
      check_hex("seg_hundreds", seg_table[0], seg_hundreds);
    end
    report("Reset state");
    forever
    begin
      @(posedge clk);                      // Strobe is driven on the falling edge
      if (test_start)
        check_frame();
    end
  end

endmodule

// ==== tests/tb_ps2_display.sv ====
module tb_ps2_display;
  timeunit 1ns;
  timeprecision 1ps;
  import ps2_pkg::*;

  localparam int NUM_TESTS    = 10;
  localparam int PS2_HALF     = 40;     // clk cycles per PS/2 half period
  localparam int DONE_TIMEOUT = 1000;
  localparam int IDLE_GAP     = 200;    // Between frames

  logic  clk;
  logic  reset;
  logic  ps2_clk;
  logic  ps2_data;
  byte_t rx_data;
  logic  rx_valid;
  logic  frame_error;
  logic  digits_valid;
  seg_t  seg_ones;
  seg_t  seg_tens;
  seg_t  seg_hundreds;
  logic  test_start;
  int    test_id;
  byte_t exp_byte;
  logic  exp_accept;
  int    checks_done;
  int    pass_count;
  int    fail_count;
  logic  aborted;

  // ------------------------------------------------------------
  // Frame table, zero bytes in rows 4, 5 and 9 get random values
  // ------------------------------------------------------------
  byte_t frame_byte [NUM_TESTS] = '{8'd42, 8'd255, 8'd0, 8'd100, 8'h00,
                                    8'h00, 8'h5a, 8'h99, 8'hc3, 8'h00};
  bit    bad_parity [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 1, 0, 0, 0};
  bit    bad_stop   [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 1, 0, 0};
  bit    glitch     [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1};
  bit    expect_ok  [NUM_TESTS] = '{1, 1, 1, 1, 1, 1, 0, 0, 1, 1};

  ps2_display_top dut0
  (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk      (ps2_clk),
    .ps2_data     (ps2_data),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .frame_error  (frame_error),
    .digits_valid (digits_valid),
    .seg_ones     (seg_ones),
    .seg_tens     (seg_tens),
    .seg_hundreds (seg_hundreds)
  );

  ps2_checker u_checker
  (
    .clk          (clk),
    .reset        (reset),
    .test_start   (test_start),
    .test_id      (test_id),
    .exp_byte     (exp_byte),
    .exp_accept   (exp_accept),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .frame_error  (frame_error),
    .digits_valid (digits_valid),
    .seg_ones     (seg_ones),
    .seg_tens     (seg_tens),
    .seg_hundreds (seg_hundreds),
    .checks_done  (checks_done),
    .pass_count   (pass_count),
    .fail_count   (fail_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Start, eight data bits LSB first, odd parity, stop
  task automatic send_frame(input byte_t data, input bit par_err, input bit stop_err,
                            input bit add_glitch);
    logic [10:0] bits;
    bits = {~stop_err, ~(^data) ^ par_err, data, 1'b0};
    for (int b = 0; b < 11; b++)
    begin
      repeat (PS2_HALF / 2) @(negedge clk);
      ps2_data = bits[b];                 // Only while the PS/2 clock is high
      repeat (PS2_HALF / 2) @(negedge clk);
      ps2_clk = 1'b0;
      for (int c = 0; c < PS2_HALF; c++)
      begin
        @(negedge clk);
        // Data bit 3 flipped for two samples of the window
        if (add_glitch && b == 4)
          ps2_data = (c == 4 || c == 5) ? ~bits[b] : bits[b];
      end
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;                      // Line idles high
  endtask

  initial
  begin
    int waited;
    void'($urandom(32'h808e));
    frame_byte[4] = byte_t'($urandom);
    frame_byte[5] = byte_t'($urandom);
    frame_byte[9] = byte_t'($urandom);
    reset      = 1'b1;
    ps2_clk    = 1'b1;
    ps2_data   = 1'b1;
    test_start = 1'b0;
    test_id    = 0;
    exp_byte   = '0;
    exp_accept = 1'b0;
    aborted    = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (20) @(negedge clk);
    for (int i = 0; i < NUM_TESTS; i++)
    begin
      test_id    = i;
      exp_byte   = frame_byte[i];
      exp_accept = expect_ok[i];
      test_start = 1'b1;
      @(negedge clk);
      test_start = 1'b0;
      send_frame(frame_byte[i], bad_parity[i], bad_stop[i], glitch[i]);
      waited = 0;
      while (checks_done < i + 1 && waited < DONE_TIMEOUT)
      begin
        @(posedge clk);
        waited++;
      end
      if (checks_done < i + 1)
      begin
        $display("Timeout: checker did not finish test %0d", i);
        aborted = 1'b1;
        break;
      end
      repeat (IDLE_GAP) @(negedge clk);
    end
    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (!aborted && fail_count == 0 && pass_count == NUM_TESTS + 1)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== list.f ====
design/ps2_pkg.sv
design/edge_sync.sv
design/bit_sampler.sv
design/ps2_frame_receiver.sv
design/base_divider.sv
design/digit_converter.sv
design/seg7_encoder.sv
design/ps2_display_top.sv
tests/ps2_checker.sv
tests/tb_ps2_display.sv
